// ==== src/ru_defs_pkg.sv ====
// remote update engine encoding
package ru_defs_pkg;

	// ======================================================================
	// field widths
	// ======================================================================
	localparam int ctrl_width  = 3;  // user control code
	localparam int param_width = 3;  // engine parameter address
	localparam int word_width  = 32; // engine data bus
	localparam int wdog_width  = 8;  // kick counter, msb is the kick

	typedef logic [ctrl_width-1:0]  ru_ctrl_t;
	typedef logic [param_width-1:0] ru_param_t;
	typedef logic [word_width-1:0]  ru_word_t;
	typedef logic [wdog_width-1:0]  wdog_count_t;

	// ======================================================================
	// control codes
	// ======================================================================
	// levels on ru_ctrl
	// read and write fire on the move away from idle
	localparam ru_ctrl_t ctrl_idle     = 3'b000;
	localparam ru_ctrl_t ctrl_read     = 3'b001; // read_param strobe
	localparam ru_ctrl_t ctrl_write    = 3'b010; // write_param strobe
	localparam ru_ctrl_t ctrl_reset    = 3'b100; // engine reset level
	localparam ru_ctrl_t ctrl_abort    = 3'b101; // skip the auto boot
	localparam ru_ctrl_t ctrl_reconfig = 3'b111; // reload from flash

	// 011 and 110 are unused
	// they decode to nothing on the engine side

endpackage

// ==== src/ru_boot_pkg.sv ====
// auto boot program
package ru_boot_pkg;

	// ======================================================================
	// sequencer types
	// ======================================================================
	typedef enum logic [2:0] {
		st_init,       // engine held in reset, timeout running
		st_load,       // table entry onto param and data
		st_strobe_hi,  // write code
		st_strobe_lo,  // back to idle so the next write can edge
		st_wait_idle,  // engine busy
		st_done_check, // next step or finish
		st_reconfig,   // terminal
		st_user        // terminal, user owns the port
	} boot_state_t;

	typedef logic [2:0] boot_step_t;

	localparam boot_step_t  boot_last_step       = 3'd3;
	localparam int unsigned boot_timeout_default = 125_000_000; // about 1 s at 125 MHz

	// ======================================================================
	// boot table
	// ======================================================================
	function automatic ru_defs_pkg::ru_param_t boot_param(input boot_step_t step);
		case (step)
			3'd0:    return 3'b101;
			3'd1:    return 3'b100;
			3'd2:    return 3'b010;
			default: return 3'b011; // step 3 and beyond
		endcase
	endfunction

	function automatic ru_defs_pkg::ru_word_t boot_data(input boot_step_t step);
		case (step)
			3'd0:    return 32'h0000_0001;
			3'd1:    return 32'h0200_0000; // image start
			3'd2:    return 32'h0000_1fff; // watchdog timeout
			default: return 32'h0000_0001; // watchdog enable
		endcase
	endfunction

endpackage

// ==== src/ru_boot_sequencer.sv ====
// auto boot sequencer
module ru_boot_sequencer #(
	parameter int unsigned boot_timeout_cycles = ru_boot_pkg::boot_timeout_default
) (
	input  logic                   clock_rd2,
	input  logic                   reset_n,
	input  ru_defs_pkg::ru_ctrl_t  ru_ctrl,    // raw user code
	input  logic                   busy_idle,  // from busy monitor
	output ru_defs_pkg::ru_ctrl_t  auto_ctrl,
	output ru_defs_pkg::ru_param_t auto_param,
	output ru_defs_pkg::ru_word_t  auto_data,
	output logic                   user_mode
);
	import ru_defs_pkg::*;
	import ru_boot_pkg::*;

	// wide enough to hold the limit itself
	localparam int unsigned cnt_width = $clog2(boot_timeout_cycles + 1);

	typedef logic [cnt_width-1:0] timeout_cnt_t;

	localparam timeout_cnt_t timeout_limit = timeout_cnt_t'(boot_timeout_cycles);

	boot_state_t  state;
	boot_state_t  state_next;
	timeout_cnt_t timeout_cnt;
	boot_step_t   step;       // table index
	ru_ctrl_t     ctrl_sync1;
	ru_ctrl_t     ctrl_sync2; // abort is looked at here only

	// ======================================================================
	// registers
	// ======================================================================
	always_ff @(posedge clock_rd2) begin
		if (!reset_n) begin
			state       <= st_init;
			timeout_cnt <= '0;
			step        <= '0;
			ctrl_sync1  <= ctrl_idle;
			ctrl_sync2  <= ctrl_idle;
		end else begin
			state      <= state_next;
			ctrl_sync1 <= ru_ctrl;
			ctrl_sync2 <= ctrl_sync1;
			if (state == st_init) begin
				timeout_cnt <= timeout_cnt + 1'b1; // stops once we leave init
			end
			if (state == st_done_check) begin
				step <= step + 1'b1;
			end
		end
	end

	// ======================================================================
	// next state
	// ======================================================================
	always_comb begin
		state_next = state;
		case (state)
			st_init: begin
				if (ctrl_sync2 == ctrl_abort) begin
					state_next = st_user; // abort wins over timeout
				end else if (timeout_cnt >= timeout_limit) begin
					state_next = st_load;
				end
			end
			st_load:      state_next = st_strobe_hi;
			st_strobe_hi: state_next = st_strobe_lo;
			st_strobe_lo: state_next = st_wait_idle;
			st_wait_idle: begin
				if (busy_idle) begin
					state_next = st_done_check;
				end
			end
			st_done_check: begin
				// step still holds the entry just written
				if (step >= boot_last_step) begin
					state_next = st_reconfig;
				end else begin
					state_next = st_load;
				end
			end
			st_reconfig:  state_next = st_reconfig; // until reset
			st_user:      state_next = st_user;     // until reset
			default:      state_next = st_init;
		endcase
	end

	// ======================================================================
	// auto outputs
	// ======================================================================
	always_comb begin
		case (state)
			st_init:      auto_ctrl = ctrl_reset;    // hold engine in reset
			st_strobe_hi: auto_ctrl = ctrl_write;
			st_reconfig:  auto_ctrl = ctrl_reconfig;
			default:      auto_ctrl = ctrl_idle;
		endcase
	end

	// table lookup straight off the step index
	assign auto_param = boot_param(step);
	assign auto_data  = boot_data(step);
	assign user_mode  = (state == st_user);

endmodule

// ==== src/ru_port_driver.sv ====
// engine port driver
module ru_port_driver (
	input  logic                   clock_rd2,
	input  logic                   reset_n,
	input  logic                   user_mode,
	input  ru_defs_pkg::ru_ctrl_t  auto_ctrl,
	input  ru_defs_pkg::ru_param_t auto_param,
	input  ru_defs_pkg::ru_word_t  auto_data,
	input  ru_defs_pkg::ru_ctrl_t  ru_ctrl,
	input  ru_defs_pkg::ru_param_t ru_param,
	input  ru_defs_pkg::ru_word_t  ru_data_in,
	output logic                   eng_reset,
	output logic                   eng_reconfig,
	output logic                   eng_read,
	output logic                   eng_write,
	output ru_defs_pkg::ru_param_t eng_param,
	output ru_defs_pkg::ru_word_t  eng_data_in,
	output logic                   eng_wdog_kick
);
	import ru_defs_pkg::*;

	ru_ctrl_t    sel_ctrl;
	ru_param_t   sel_param;
	ru_word_t    sel_data;
	ru_ctrl_t    ctrl_q;    // current code
	ru_ctrl_t    ctrl_last; // code one cycle back, for the edges
	wdog_count_t wdog_cnt;

	// ======================================================================
	// mode mux
	// ======================================================================
	assign sel_ctrl  = user_mode ? ru_ctrl    : auto_ctrl;
	assign sel_param = user_mode ? ru_param   : auto_param;
	assign sel_data  = user_mode ? ru_data_in : auto_data;

	// param and data one cycle ahead of the strobe
	always_ff @(posedge clock_rd2) begin
		if (!reset_n) begin
			ctrl_q      <= ctrl_idle;
			ctrl_last   <= ctrl_idle;
			eng_param   <= '0;
			eng_data_in <= '0;
		end else begin
			ctrl_q      <= sel_ctrl;
			ctrl_last   <= ctrl_q;
			eng_param   <= sel_param;
			eng_data_in <= sel_data;
		end
	end

	// ======================================================================
	// decode
	// ======================================================================
	always_ff @(posedge clock_rd2) begin
		if (!reset_n) begin
			eng_reset    <= 1'b0;
			eng_reconfig <= 1'b0;
			eng_read     <= 1'b0;
			eng_write    <= 1'b0;
		end else begin
			eng_reset    <= (ctrl_q == ctrl_reset);    // level, active high
			eng_reconfig <= (ctrl_q == ctrl_reconfig); // level
			// idle to read or write only, so a held code strobes once
			eng_read     <= (ctrl_q == ctrl_read) && (ctrl_last == ctrl_idle);
			eng_write    <= (ctrl_q == ctrl_write) && (ctrl_last == ctrl_idle);
		end
	end

	// watchdog kick, free running
	always_ff @(posedge clock_rd2) begin
		if (!reset_n) begin
			wdog_cnt <= '0;
		end else begin
			wdog_cnt <= wdog_cnt + 1'b1;
		end
	end

	assign eng_wdog_kick = wdog_cnt[wdog_width-1]; // toggles every 128 cycles

endmodule

// ==== src/ru_busy_monitor.sv ====
// engine busy monitor
module ru_busy_monitor (
	input  logic                  clock_rd2,
	input  logic                  reset_n,
	input  logic                  eng_busy,     // from engine, treated as async
	input  ru_defs_pkg::ru_word_t eng_data_out,
	output logic                  busy_idle,
	output ru_defs_pkg::ru_word_t ru_data_out
);

	logic [2:0] busy_hist; // [0] is the sync stage, [2] the oldest
	logic       busy_fall;

	// ======================================================================
	// busy history
	// ======================================================================
	always_ff @(posedge clock_rd2) begin
		if (!reset_n) begin
			busy_hist <= '0;
		end else begin
			busy_hist <= {busy_hist[1:0], eng_busy};
		end
	end

	// only the two settled samples count
	assign busy_idle = (busy_hist[2:1] == 2'b00);
	assign busy_fall = (busy_hist[2:1] == 2'b10); // was high, now low

	// ======================================================================
	// read data capture
	// ======================================================================
	// engine data is valid once busy drops
	// held until the next read finishes
	always_ff @(posedge clock_rd2) begin
		if (!reset_n) begin
			ru_data_out <= '0;
		end else if (busy_fall) begin
			ru_data_out <= eng_data_out;
		end
	end

endmodule

// ==== src/remote_update_ctrl.sv ====
// remote update controller
module remote_update_ctrl #(
	parameter int unsigned boot_timeout_cycles = ru_boot_pkg::boot_timeout_default
) (
	input  logic                   clock_rd2,
	input  logic                   reset_n,
	// user side
	input  ru_defs_pkg::ru_ctrl_t  ru_ctrl,
	input  ru_defs_pkg::ru_param_t ru_param,
	input  ru_defs_pkg::ru_word_t  ru_data_in,
	output ru_defs_pkg::ru_word_t  ru_data_out,
	// engine side
	output logic                   eng_reset,
	output logic                   eng_reconfig,
	output logic                   eng_read,
	output logic                   eng_write,
	output logic                   eng_wdog_kick,
	output ru_defs_pkg::ru_param_t eng_param,
	output ru_defs_pkg::ru_word_t  eng_data_in,
	input  logic                   eng_busy,
	input  ru_defs_pkg::ru_word_t  eng_data_out
);
	import ru_defs_pkg::*;

	ru_ctrl_t  auto_ctrl;
	ru_param_t auto_param;
	ru_word_t  auto_data;
	logic      user_mode;
	logic      busy_idle; // monitor back to sequencer

	// ======================================================================
	// boot sequencer
	// ======================================================================
	ru_boot_sequencer #(
		.boot_timeout_cycles (boot_timeout_cycles)
	) u_boot_sequencer (
		.clock_rd2  (clock_rd2),
		.reset_n    (reset_n),
		.ru_ctrl    (ru_ctrl),
		.busy_idle  (busy_idle),
		.auto_ctrl  (auto_ctrl),
		.auto_param (auto_param),
		.auto_data  (auto_data),
		.user_mode  (user_mode)
	);

	// ======================================================================
	// engine port
	// ======================================================================
	ru_port_driver u_port_driver (
		.clock_rd2     (clock_rd2),
		.reset_n       (reset_n),
		.user_mode     (user_mode),
		.auto_ctrl     (auto_ctrl),
		.auto_param    (auto_param),
		.auto_data     (auto_data),
		.ru_ctrl       (ru_ctrl),     // same raw input the sequencer syncs
		.ru_param      (ru_param),
		.ru_data_in    (ru_data_in),
		.eng_reset     (eng_reset),
		.eng_reconfig  (eng_reconfig),
		.eng_read      (eng_read),
		.eng_write     (eng_write),
		.eng_param     (eng_param),
		.eng_data_in   (eng_data_in),
		.eng_wdog_kick (eng_wdog_kick)
	);

	// busy and read data back from the engine
	ru_busy_monitor u_busy_monitor (
		.clock_rd2    (clock_rd2),
		.reset_n      (reset_n),
		.eng_busy     (eng_busy),
		.eng_data_out (eng_data_out),
		.busy_idle    (busy_idle),
		.ru_data_out  (ru_data_out)
	);

endmodule

// ==== dv/ru_engine_model.sv ====
// remote update engine model
module ru_engine_model (
	input  logic                   clock_rd2,
	input  logic                   reset_n,
	input  logic                   eng_read,     // one cycle strobe
	input  logic                   eng_write,    // one cycle strobe
	input  ru_defs_pkg::ru_param_t eng_param,
	input  ru_defs_pkg::ru_word_t  eng_data_in,
	output logic                   eng_busy,
	output ru_defs_pkg::ru_word_t  eng_data_out,
	output int                     write_count
);
	timeunit 1ns;
	timeprecision 100ps;
	import ru_defs_pkg::*;

	logic [31:0] lfsr = 32'hdaee;
	int          busy_left;
	ru_param_t   log_param [16]; // write log, param side
	ru_word_t    log_data [16];

	// galois step, taps for a 32 bit maximal sequence
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val  = {val[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return val;
	endfunction

	assign eng_busy = (busy_left != 0);

	always @(posedge clock_rd2) begin
		if (!reset_n) begin
			busy_left    <= 0;
			eng_data_out <= '0;
			write_count  <= 0;
		end else begin
			if (eng_write) begin
				log_param[write_count[3:0]] <= eng_param; // recorded even while busy
				log_data[write_count[3:0]]  <= eng_data_in;
				write_count                 <= write_count + 1;
			end
			if (eng_read) begin
				eng_data_out <= take_bits(32); // valid when busy drops
			end
			if (eng_read || eng_write) begin
				busy_left <= 3 + int'(take_bits(3)); // 3 to 10 cycles
			end else if (busy_left != 0) begin
				busy_left <= busy_left - 1;
			end
		end
	end

endmodule

// ==== dv/tb_remote_update_ctrl.sv ====
// remote update controller testbench
module tb_remote_update_ctrl;
	timeunit 1ns;
	timeprecision 100ps;
	import ru_defs_pkg::*;

	localparam int timeout_cycles = 64;
	localparam int wait_limit     = 2000; // per wait loop

	// expected boot program
	localparam logic [2:0]  exp_param [4] = '{3'b101, 3'b100, 3'b010, 3'b011};
	localparam logic [31:0] exp_data [4]  = '{32'h1, 32'h0200_0000, 32'h1fff, 32'h1};

	logic      clock_rd2 = 1'b0;
	logic      reset_n;
	ru_ctrl_t  ru_ctrl;
	ru_param_t ru_param;
	ru_word_t  ru_data_in;
	ru_word_t  ru_data_out;
	logic      eng_reset;
	logic      eng_reconfig;
	logic      eng_read;
	logic      eng_write;
	logic      eng_wdog_kick;
	ru_param_t eng_param;
	ru_word_t  eng_data_in;
	logic      eng_busy;
	ru_word_t  eng_data_out;
	int        write_count;

	logic [31:0] lfsr = 32'hdaee;
	int          errors = 0;
	int          timeouts = 0;
	int          phase = 0;      // 0 auto boot, 1 abort, 2 user
	int          rel_cnt = 0;    // cycles since reset release
	int          write_idx = 0;  // auto writes seen
	int          user_writes = 0;
	int          user_reads = 0;
	logic        reconfig_seen = 1'b0;
	logic        reset_low_exp = 1'b0;
	int          level_exp = 0;  // 1 reset level, 2 reconfig level
	logic        data_check = 1'b0;
	ru_word_t    data_exp;
	logic        kick_prev = 1'b0;
	logic        kick_armed = 1'b0;
	int          kick_gap = 0;
	int          kick_checks = 0;

	always #4 clock_rd2 = ~clock_rd2;

	remote_update_ctrl #(.boot_timeout_cycles(timeout_cycles)) dut_i (.*);

	ru_engine_model engine_i (.*);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val  = {val[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return val;
	endfunction

	// ======================================================================
	// checkers
	// ======================================================================
	always @(posedge clock_rd2) begin
		if (!reset_n) begin
			rel_cnt    = 0;
			write_idx  = 0;
			kick_armed = 1'b0;
			kick_prev  = 1'b0;
			kick_gap   = 0;
		end else begin
			if (phase == 0) begin
				assert (!eng_read) else begin
					errors++;
					$display("error %0t: read strobe during auto boot", $time);
				end
				if (rel_cnt >= 3 && rel_cnt < timeout_cycles) begin
					assert (eng_reset) else begin
						errors++;
						$display("error %0t: engine reset low before first write", $time);
					end
				end
				if (eng_write) begin
					assert (write_idx < 4 && rel_cnt >= timeout_cycles) else begin
						errors++;
						$display("error %0t: unexpected auto write %0d at cycle %0d",
							$time, write_idx, rel_cnt);
					end
					if (write_idx < 4) begin
						assert (eng_param == exp_param[write_idx] &&
							eng_data_in == exp_data[write_idx]) else begin
							errors++;
							$display("error %0t: step %0d wrote %b/%h", $time,
								write_idx, eng_param, eng_data_in);
						end
					end
					write_idx++;
				end
				if (eng_reconfig && !reconfig_seen) begin
					assert (write_idx == 4) else begin
						errors++;
						$display("error %0t: reconfig after %0d writes", $time, write_idx);
					end
					reconfig_seen = 1'b1;
				end
				assert (!reconfig_seen || eng_reconfig) else begin
					errors++;
					$display("error %0t: reconfig level dropped", $time);
				end
			end else if (phase == 1) begin
				assert (!eng_write && !eng_reconfig && !eng_read) else begin
					errors++;
					$display("error %0t: engine activity after abort", $time);
				end
			end else begin
				if (eng_write) begin
					user_writes++;
					assert (eng_param == ru_param && eng_data_in == ru_data_in) else begin
						errors++;
						$display("error %0t: user write carried %b/%h", $time,
							eng_param, eng_data_in);
					end
				end
				if (eng_read) begin
					user_reads++;
					assert (eng_param == ru_param) else begin
						errors++;
						$display("error %0t: read param %b, expected %b", $time,
							eng_param, ru_param);
					end
				end
			end
			assert (!reset_low_exp || !eng_reset) else begin
				errors++;
				$display("error %0t: engine reset high after abort released", $time);
			end
			assert (level_exp != 1 || (eng_reset && !eng_reconfig)) else begin
				errors++;
				$display("error %0t: reset code did not give reset level", $time);
			end
			assert (level_exp != 2 || (eng_reconfig && !eng_reset)) else begin
				errors++;
				$display("error %0t: reconfig code did not give reconfig level", $time);
			end
			assert (!data_check || ru_data_out == data_exp) else begin
				errors++;
				$display("error %0t: read data %h, expected %h", $time,
					ru_data_out, data_exp);
			end
			// watchdog period
			kick_gap++;
			if (eng_wdog_kick != kick_prev) begin
				if (kick_armed) begin
					kick_checks++;
					assert (kick_gap == 128) else begin
						errors++;
						$display("error %0t: kick toggled after %0d cycles", $time, kick_gap);
					end
				end
				kick_armed = 1'b1;
				kick_gap   = 0;
			end
			kick_prev = eng_wdog_kick;
			rel_cnt++;
		end
	end

	// ======================================================================
	// stimulus helpers
	// ======================================================================
	task automatic step_cycles(input int n);
		repeat (n) @(posedge clock_rd2);
		#1;
	endtask

	task automatic end_run();
		$display("checks done: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	task automatic give_up(input string what);
		$display("timed out waiting for %s", what);
		timeouts++;
		end_run();
	endtask

	task automatic apply_reset();
		reset_n = 1'b0;
		step_cycles(16);
		reset_n = 1'b1;
	endtask

	task automatic wait_reconfig();
		for (int i = 0; i < wait_limit && !eng_reconfig; i++) begin
			step_cycles(1);
		end
		if (!eng_reconfig) begin
			give_up("reconfig at the end of auto boot");
		end
	endtask

	task automatic wait_busy(input logic level);
		for (int i = 0; i < wait_limit && eng_busy != level; i++) begin
			step_cycles(1);
		end
		if (eng_busy != level) begin
			give_up("engine busy to change");
		end
	endtask

	task automatic user_read();
		ru_param = ru_param_t'(random_bits(3));
		step_cycles(1);
		ru_ctrl = ctrl_read;
		wait_busy(1'b1);
		wait_busy(1'b0);  // old value must hold up to here
		data_check = 1'b0;
		ru_ctrl    = ctrl_idle;
		step_cycles(5);
		data_exp   = eng_data_out;
		data_check = 1'b1;
	endtask

	// ======================================================================
	// main sequence
	// ======================================================================
	initial begin
		reset_n    = 1'b0;
		ru_ctrl    = ctrl_idle;
		ru_param   = '0;
		ru_data_in = '0;
		step_cycles(1);
		apply_reset();
		wait_reconfig();
		step_cycles(300);
		assert (write_count == 4) else begin
			errors++;
			$display("error %0t: engine logged %0d writes", $time, write_count);
		end
		// engine log against the boot table
		for (int i = 0; i < 4; i++) begin
			assert (engine_i.log_param[i] == exp_param[i] &&
				engine_i.log_data[i] == exp_data[i]) else begin
				errors++;
				$display("error %0t: engine log entry %0d holds %b/%h", $time, i,
					engine_i.log_param[i], engine_i.log_data[i]);
			end
		end
		// abort during the countdown
		phase   = 1;
		ru_ctrl = ctrl_abort;
		apply_reset();
		step_cycles(100);
		ru_ctrl = ctrl_idle;
		step_cycles(4);
		reset_low_exp = 1'b1;
		phase         = 2;
		user_read();
		step_cycles(20);
		user_read();
		assert (user_reads == 2) else begin
			errors++;
			$display("error %0t: %0d read strobes for 2 reads", $time, user_reads);
		end
		ru_param   = ru_param_t'(random_bits(3));
		ru_data_in = random_bits(32);
		step_cycles(1);
		ru_ctrl = ctrl_write;
		step_cycles(8);
		ru_ctrl = ctrl_idle;
		wait_busy(1'b0);
		assert (user_writes == 1) else begin
			errors++;
			$display("error %0t: %0d write strobes for one held code", $time, user_writes);
		end
		reset_low_exp = 1'b0;
		ru_ctrl = ctrl_reset;
		step_cycles(3);
		level_exp = 1;
		step_cycles(10);
		level_exp = 0;
		ru_ctrl = ctrl_reconfig;
		step_cycles(3);
		level_exp = 2;
		step_cycles(10);
		level_exp = 0;
		ru_ctrl = ctrl_idle;
		step_cycles(300);
		assert (kick_checks >= 2) else begin
			errors++;
			$display("error %0t: only %0d watchdog periods seen", $time, kick_checks);
		end
		end_run();
	end

endmodule

// ==== compile.f ====
src/ru_defs_pkg.sv
src/ru_boot_pkg.sv
src/ru_boot_sequencer.sv
src/ru_port_driver.sv
src/ru_busy_monitor.sv
src/remote_update_ctrl.sv
dv/ru_engine_model.sv
dv/tb_remote_update_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, then check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module tb_remote_update_ctrl \
	-f compile.f \
	-o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	; cat sim.log \
	&& grep -qx "Simulation passed" sim.log \
	&& echo "run passed" \
	|| { echo "run failed"; exit 1; }
